//--- common/cipher_pkg.sv
`default_nettype none

package cipher_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int KEY_LEN      = 12;                   // characters per key
  localparam int GRID_DIM     = 6;                    // labels per axis, grid side
  localparam int CELL_COUNT   = GRID_DIM * GRID_DIM;  // 36 cells in the inner grid
  localparam int LETTER_COUNT = 26;                   // cells 0..25 hold a..z

  // ----------------------------------------
  // plain vector types
  // ----------------------------------------
  typedef logic [7:0] char_t;                         // one ascii character
  typedef logic [0:KEY_LEN-1][7:0] key_t;             // key[0] is the first character
  typedef logic [0:GRID_DIM-1][7:0] label_set_t;      // one axis, slot 0 first
  typedef logic [2:0] grid_idx_t;                     // row or column number
  typedef logic [$clog2(CELL_COUNT)-1:0] cell_idx_t;  // row-major cell 0..35
  typedef logic [$clog2(KEY_LEN)-1:0] key_pos_t;      // position inside the key

  // ascii ranges
  localparam char_t UPPER_A = 8'h41;
  localparam char_t UPPER_Z = 8'h5a;
  localparam char_t LOWER_A = 8'h61;
  localparam char_t LOWER_Z = 8'h7a;
  localparam char_t DIGIT_0 = 8'h30;
  localparam char_t DIGIT_9 = 8'h39;

  // key positions that feed label slots 0..5
  localparam key_pos_t [0:GRID_DIM-1] ROW_LOAD_ORDER = {
    4'd0, 4'd10, 4'd2, 4'd8, 4'd4, 4'd6
  };
  localparam key_pos_t [0:GRID_DIM-1] COL_LOAD_ORDER = {
    4'd1, 4'd11, 4'd3, 4'd9, 4'd5, 4'd7
  };

  // ----------------------------------------
  // grouped signals
  // ----------------------------------------
  typedef struct packed {
    label_set_t rows;     // upper 48 bits
    label_set_t cols;     // lower 48 bits
  } labels_t;

  typedef struct packed {
    char_t row_char;      // upper byte of the ciphertext pair
    char_t col_char;
  } ctxt_pair_t;

  // character classes, shared by key check and plaintext path
  function automatic logic is_upper(input char_t c);
    return (c >= UPPER_A) && (c <= UPPER_Z);
  endfunction

  function automatic logic is_lower(input char_t c);
    return (c >= LOWER_A) && (c <= LOWER_Z);
  endfunction

  function automatic logic is_digit(input char_t c);
    return (c >= DIGIT_0) && (c <= DIGIT_9);
  endfunction

  function automatic logic is_alnum(input char_t c);
    return is_upper(c) || is_lower(c) || is_digit(c);
  endfunction

endpackage

`default_nettype wire

//--- compile.f
+incdir+tb
common/cipher_pkg.sv
key_sched/key_checker.sv
key_sched/label_rotator.sv
rtl/polybius_encoder.sv
rtl/cipher_control.sv
rtl/rotating_square_cipher.sv
tb/cipher_tb.sv

//--- key_sched/key_checker.sv
`default_nettype none

module key_checker (
  input  wire cipher_pkg::key_t key,
  output logic                  key_ok   // all alphanumeric, no repeats
);

  import cipher_pkg::*;

  logic [KEY_LEN-1:0] char_alnum;   // one flag per key character
  logic               dup_found;    // some pair of characters matches

  // ----------------------------------------
  // per character class
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < KEY_LEN; i++) begin
      char_alnum[i] = is_alnum(key[i]);   // upper, lower or digit
    end
  end

  // ----------------------------------------
  // uniqueness
  // ----------------------------------------
  // only the upper triangle of pairs is compared
  // 'A' and 'a' count as different characters here
  always_comb begin
    dup_found = 1'b0;
    for (int i = 0; i < KEY_LEN - 1; i++) begin
      for (int j = i + 1; j < KEY_LEN; j++) begin
        if (key[i] == key[j]) begin
          dup_found = 1'b1;
        end
      end
    end
  end

  assign key_ok = (&char_alnum) && !dup_found;

endmodule

`default_nettype wire

//--- key_sched/label_rotator.sv
`default_nettype none

module label_rotator (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire cipher_pkg::key_t    key,
  input  wire                      load,      // install the key labels
  input  wire                      advance,   // rotate after an accepted char
  output cipher_pkg::labels_t      labels
);

  import cipher_pkg::*;

  label_set_t rows_load;   // key scattered into row slots
  label_set_t cols_load;   // key scattered into column slots
  label_set_t rows_rot;    // row slots shifted by one
  label_set_t cols_rot;    // column slots shifted by one

  // ----------------------------------------
  // load values
  // ----------------------------------------
  // rows take the even key positions and columns the odd ones
  // in the interleaved order of the package tables
  always_comb begin
    for (int s = 0; s < GRID_DIM; s++) begin
      rows_load[s] = key[ROW_LOAD_ORDER[s]];
      cols_load[s] = key[COL_LOAD_ORDER[s]];
    end
  end

  // ----------------------------------------
  // rotate values
  // ----------------------------------------
  // slot i goes to slot i+1 and the last slot wraps to slot 0
  assign rows_rot = {labels.rows[GRID_DIM-1], labels.rows[0:GRID_DIM-2]};
  assign cols_rot = {labels.cols[GRID_DIM-1], labels.cols[0:GRID_DIM-2]};

  // ----------------------------------------
  // label registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      labels <= '0;                 // no key installed yet
    end else if (load) begin
      labels.rows <= rows_load;     // a new key replaces any old labels
      labels.cols <= cols_load;
    end else if (advance) begin
      labels.rows <= rows_rot;
      labels.cols <= cols_rot;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cipher_control.sv
`default_nettype none

module cipher_control (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        key_valid,
  input  wire                        ptxt_valid,
  input  wire                        key_ok,       // from key_checker
  input  wire                        char_ok,      // from polybius_encoder
  input  wire cipher_pkg::ctxt_pair_t pair,        // current label pair
  output logic                       load,         // same-edge label load
  output logic                       advance,      // same-edge label rotate
  output cipher_pkg::ctxt_pair_t     ctxt_str,
  output logic                       ctxt_ready,
  output logic                       err_invalid_key,
  output logic                       err_invalid_ptxt,
  output logic                       err_key_not_installed
);

  import cipher_pkg::*;

  logic installed;      // a good key has been loaded since reset
  logic ptxt_take;      // plaintext strobe that is not shadowed by a key
  logic bad_key;
  logic no_key;
  logic bad_char;

  // ----------------------------------------
  // decisions for this edge
  // ----------------------------------------
  // key strobe wins over plaintext on the same cycle
  assign ptxt_take = ptxt_valid && !key_valid;

  assign load     = key_valid && key_ok;
  assign bad_key  = key_valid && !key_ok;   // labels and installed untouched

  assign no_key   = ptxt_take && !installed;
  assign bad_char = ptxt_take && installed && !char_ok;
  assign advance  = ptxt_take && installed && char_ok;   // accepted character

  // ----------------------------------------
  // installed flag
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      installed <= 1'b0;
    end else if (load) begin
      installed <= 1'b1;   // stays set, a later key only swaps the labels
    end
  end

  // ----------------------------------------
  // output pulses, one cycle each
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_ready            <= 1'b0;
      ctxt_str              <= '0;
      err_invalid_key       <= 1'b0;
      err_invalid_ptxt      <= 1'b0;
      err_key_not_installed <= 1'b0;
    end else begin
      ctxt_ready            <= advance;
      ctxt_str              <= advance ? pair : '0;   // pair uses pre-rotation labels
      err_invalid_key       <= bad_key;
      err_invalid_ptxt      <= bad_char;
      err_key_not_installed <= no_key;
    end
  end

endmodule

`default_nettype wire

//--- rtl/polybius_encoder.sv
`default_nettype none

module polybius_encoder (
  input  wire cipher_pkg::char_t   ptxt_char,
  input  wire cipher_pkg::labels_t labels,
  output logic                     char_ok,   // letter or digit
  output cipher_pkg::ctxt_pair_t   pair       // {row label, column label}
);

  import cipher_pkg::*;

  logic      up_case;     // input is A..Z
  char_t     folded;      // input with upper case moved to lower case
  logic      is_letter;
  logic      is_num;
  cell_idx_t cell_idx;    // row-major position in the fixed grid
  grid_idx_t row_idx;
  grid_idx_t col_idx;

  // ----------------------------------------
  // classify and fold case
  // ----------------------------------------
  assign up_case   = is_upper(ptxt_char);
  assign folded    = up_case ? char_t'(ptxt_char - UPPER_A + LOWER_A) : ptxt_char;
  assign is_letter = is_lower(folded);
  assign is_num    = is_digit(ptxt_char);
  assign char_ok   = is_letter || is_num;

  // letters fill cells 0..25, digits continue at 26..35
  always_comb begin
    if (is_letter) begin
      cell_idx = cell_idx_t'(folded - LOWER_A);
    end else if (is_num) begin
      cell_idx = cell_idx_t'(LETTER_COUNT + (ptxt_char - DIGIT_0));
    end else begin
      cell_idx = '0;   // pair is don't care when char_ok is low
    end
  end

  // ----------------------------------------
  // grid position and label select
  // ----------------------------------------
  assign row_idx = grid_idx_t'(cell_idx / GRID_DIM);   // constant divide by 6
  assign col_idx = grid_idx_t'(cell_idx % GRID_DIM);

  assign pair.row_char = labels.rows[row_idx];
  assign pair.col_char = labels.cols[col_idx];

endmodule

`default_nettype wire

//--- rtl/rotating_square_cipher.sv
`default_nettype none

module rotating_square_cipher (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         key_valid,
  input  wire cipher_pkg::key_t       key,
  input  wire                         ptxt_valid,
  input  wire cipher_pkg::char_t      ptxt_char,
  output cipher_pkg::ctxt_pair_t      ctxt_str,
  output logic                        ctxt_ready,
  output logic                        err_invalid_key,
  output logic                        err_invalid_ptxt,
  output logic                        err_key_not_installed
);

  import cipher_pkg::*;

  logic       key_ok;    // checked key is usable
  logic       char_ok;   // plaintext is alphanumeric
  ctxt_pair_t pair;      // label pair for the current character
  labels_t    labels;    // live row and column labels
  logic       load;
  logic       advance;

  // ----------------------------------------
  // key path
  // ----------------------------------------
  key_checker key_checker_i (
    .key    (key),
    .key_ok (key_ok)
  );

  label_rotator label_rotator_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .key     (key),
    .load    (load),
    .advance (advance),
    .labels  (labels)
  );

  // ----------------------------------------
  // plaintext path
  // ----------------------------------------
  polybius_encoder polybius_encoder_i (
    .ptxt_char (ptxt_char),
    .labels    (labels),
    .char_ok   (char_ok),
    .pair      (pair)
  );

  cipher_control cipher_control_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .key_valid             (key_valid),
    .ptxt_valid            (ptxt_valid),
    .key_ok                (key_ok),
    .char_ok               (char_ok),
    .pair                  (pair),
    .load                  (load),
    .advance               (advance),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_key       (err_invalid_key),
    .err_invalid_ptxt      (err_invalid_ptxt),
    .err_key_not_installed (err_key_not_installed)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cipher testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary -j 0 --top-module cipher_tb -f compile.f -o cipher_sim

# $fatal gives a nonzero exit, tee keeps the pipeline going so the log decides
./obj_dir/cipher_sim 2>&1 | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

echo "simulation passed"
exit 0

//--- tb/cipher_ref.svh
`ifndef CIPHER_REF_SVH
`define CIPHER_REF_SVH

// ----------------------------------------
// reference model state
// ----------------------------------------
logic [7:0] model_rows [6];   // row labels, slot 0 first
logic [7:0] model_cols [6];   // column labels
logic       model_installed;  // a good key was seen

// key positions feeding label slots 0..5
localparam int ROW_SRC [6] = '{0, 10, 2, 8, 4, 6};
localparam int COL_SRC [6] = '{1, 11, 3, 9, 5, 7};

// character pos of a 12-char key, pos 0 in the top byte
function automatic logic [7:0] key_char(input logic [95:0] k, input int pos);
  return k[95 - 8*pos -: 8];
endfunction

function automatic logic char_is_alnum(input logic [7:0] c);
  return (c >= "0" && c <= "9") || (c >= "A" && c <= "Z") || (c >= "a" && c <= "z");
endfunction

// every char alphanumeric and no two equal (case matters)
function automatic logic ref_key_ok(input logic [95:0] k);
  logic ok;
  ok = 1'b1;
  for (int i = 0; i < 12; i++) begin
    if (!char_is_alnum(key_char(k, i))) ok = 1'b0;
    for (int j = 0; j < i; j++) begin
      if (key_char(k, i) == key_char(k, j)) ok = 1'b0;
    end
  end
  return ok;
endfunction

// a..z -> 0..25, digits -> 26..35, -1 for anything else
function automatic int ref_index(input logic [7:0] c);
  if (c >= "a" && c <= "z") return int'(c - "a");
  if (c >= "A" && c <= "Z") return int'(c - "A");   // case folded
  if (c >= "0" && c <= "9") return 26 + int'(c - "0");
  return -1;
endfunction

task automatic clear_model();
  for (int i = 0; i < 6; i++) begin
    model_rows[i] = 8'h00;
    model_cols[i] = 8'h00;
  end
  model_installed = 1'b0;
endtask

task automatic load_labels(input logic [95:0] k);
  for (int i = 0; i < 6; i++) begin
    model_rows[i] = key_char(k, ROW_SRC[i]);
    model_cols[i] = key_char(k, COL_SRC[i]);
  end
  model_installed = 1'b1;
endtask

// slot i moves to i+1, slot 5 wraps to slot 0
task automatic rotate_labels();
  logic [7:0] last_row;
  logic [7:0] last_col;
  last_row = model_rows[5];
  last_col = model_cols[5];
  for (int i = 5; i > 0; i--) begin
    model_rows[i] = model_rows[i-1];
    model_cols[i] = model_cols[i-1];
  end
  model_rows[0] = last_row;
  model_cols[0] = last_col;
endtask

function automatic logic [15:0] ref_pair(input int idx);
  return {model_rows[idx / 6], model_cols[idx % 6]};   // row label in upper byte
endfunction

`endif

//--- tb/cipher_tb.sv
`default_nettype none

module cipher_tb;

  logic        clk;
  logic        rst_n;
  logic        key_valid;
  logic [95:0] key;
  logic        ptxt_valid;
  logic [7:0]  ptxt_char;
  logic [15:0] ctxt_str;
  logic        ctxt_ready;
  logic        err_invalid_key;
  logic        err_invalid_ptxt;
  logic        err_key_not_installed;

  // expected outputs for the next negedge
  logic [15:0] exp_str;
  logic        exp_ready;
  logic        exp_bad_key;
  logic        exp_bad_ptxt;
  logic        exp_no_key;

  logic [31:0] rng_state;

  `include "cipher_ref.svh"

  rotating_square_cipher dut_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .key_valid             (key_valid),
    .key                   (key),
    .ptxt_valid            (ptxt_valid),
    .ptxt_char             (ptxt_char),
    .ctxt_str              (ctxt_str),
    .ctxt_ready            (ctxt_ready),
    .err_invalid_key       (err_invalid_key),
    .err_invalid_ptxt      (err_invalid_ptxt),
    .err_key_not_installed (err_key_not_installed)
  );

  always #5 clk = ~clk;   // 10 unit period

  // ----------------------------------------
  // checking
  // ----------------------------------------
  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch");
    end
  endtask

  // outputs are stable at negedge, inputs were driven just after the posedge
  always @(negedge clk) begin : compare_outputs
    int idx;
    if (!rst_n) begin
      clear_model();
      exp_str      = 16'h0000;
      exp_ready    = 1'b0;
      exp_bad_key  = 1'b0;
      exp_bad_ptxt = 1'b0;
      exp_no_key   = 1'b0;
    end else begin
      check_value("ctxt_ready", 16'(exp_ready), 16'(ctxt_ready));
      check_value("ctxt_str", exp_str, ctxt_str);
      check_value("err_invalid_key", 16'(exp_bad_key), 16'(err_invalid_key));
      check_value("err_invalid_ptxt", 16'(exp_bad_ptxt), 16'(err_invalid_ptxt));
      check_value("err_key_not_installed", 16'(exp_no_key), 16'(err_key_not_installed));
      // predict what the coming edge produces
      exp_str      = 16'h0000;
      exp_ready    = 1'b0;
      exp_bad_key  = 1'b0;
      exp_bad_ptxt = 1'b0;
      exp_no_key   = 1'b0;
      if (key_valid) begin             // key wins, plaintext ignored
        if (ref_key_ok(key)) load_labels(key);
        else exp_bad_key = 1'b1;
      end else if (ptxt_valid) begin
        idx = ref_index(ptxt_char);
        if (!model_installed) begin
          exp_no_key = 1'b1;
        end else if (idx < 0) begin
          exp_bad_ptxt = 1'b1;         // no rotation
        end else begin
          exp_ready = 1'b1;
          exp_str   = ref_pair(idx);   // labels before the rotate
          rotate_labels();
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int rand_below(input int n);
    rng_state = lcg_step(rng_state);
    return int'(rng_state[31:8]) % n;   // upper bits are the better ones
  endfunction

  // 0..25 lower, 26..51 upper, 52..61 digits
  function automatic logic [7:0] alnum_from(input int n);
    if (n < 26) return 8'("a" + n);
    if (n < 52) return 8'("A" + n - 26);
    return 8'("0" + n - 52);
  endfunction

  function automatic logic [7:0] random_bad_char();
    logic [7:0] c;
    c = 8'(rand_below(256));
    while (ref_index(c) >= 0) c = 8'(rand_below(256));
    return c;
  endfunction

  // twelve distinct alphanumeric characters
  function automatic logic [95:0] random_key();
    logic [95:0] k;
    logic [7:0]  c;
    int          pos;
    logic        seen;
    k   = '0;
    pos = 0;
    while (pos < 12) begin
      c    = alnum_from(rand_below(62));
      seen = 1'b0;
      for (int j = 0; j < pos; j++) begin
        if (key_char(k, j) == c) seen = 1'b1;
      end
      if (!seen) begin
        k[95 - 8*pos -: 8] = c;
        pos++;
      end
    end
    return k;
  endfunction

  task automatic drive(input logic kv, input logic [95:0] k, input logic pv,
                       input logic [7:0] c);
    @(posedge clk);
    #1;
    key_valid  = kv;
    key        = k;
    ptxt_valid = pv;
    ptxt_char  = c;
  endtask

  task automatic send_key(input logic [95:0] k);
    drive(1'b1, k, 1'b0, 8'h00);
  endtask

  task automatic send_char(input logic [7:0] c);
    drive(1'b0, key, 1'b1, c);
  endtask

  task automatic go_idle();
    drive(1'b0, key, 1'b0, 8'h00);
  endtask

  function automatic logic output_bit(input int sel);
    case (sel)
      0:       return ctxt_ready;
      1:       return err_invalid_key;
      2:       return err_invalid_ptxt;
      default: return err_key_not_installed;
    endcase
  endfunction

  task automatic wait_for_output(input int sel, input string name);
    int cycles;
    cycles = 0;
    while (output_bit(sel) !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 8) begin
        $display("timeout: %s did not go high within 8 cycles", name);
        $display("ERRORS FOUND");
        $fatal(1, "wait timed out");
      end
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    logic [95:0] k;
    clk        = 1'b0;
    rst_n      = 1'b0;
    key_valid  = 1'b0;
    key        = '0;
    ptxt_valid = 1'b0;
    ptxt_char  = 8'h00;
    rng_state  = 32'hd9f1e5a7;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    go_idle();

    // plaintext before any key
    send_char("h");
    go_idle();
    wait_for_output(3, "err_key_not_installed");
    send_char("Q");
    go_idle();

    // repeated character, then a non-alphanumeric one
    k = random_key();
    k[95 - 8*7 -: 8] = key_char(k, 2);
    send_key(k);
    go_idle();
    wait_for_output(1, "err_invalid_key");
    send_char("7");
    k = random_key();
    k[95 - 8*4 -: 8] = random_bad_char();
    send_key(k);
    send_char("m");                  // still not installed
    go_idle();

    // good key then back-to-back mixed case stream
    send_key(random_key());
    for (int n = 0; n < 40; n++) begin
      send_char(alnum_from(rand_below(62)));
    end
    go_idle();
    wait_for_output(0, "ctxt_ready");

    // bad key keeps the old labels
    k = random_key();
    k[95 - 8*11 -: 8] = key_char(k, 0);
    send_key(k);
    send_char("z");
    send_char("Z");

    // invalid char gives no rotation
    send_char("#");
    send_char("a");
    send_char(8'h00);
    send_char("a");
    go_idle();
    wait_for_output(0, "ctxt_ready");
    for (int n = 0; n < 30; n++) begin
      if (rand_below(5) == 0) send_char(random_bad_char());
      else send_char(alnum_from(rand_below(62)));
    end

    // key and plaintext together, only the key counts
    drive(1'b1, random_key(), 1'b1, "b");
    send_char("b");
    drive(1'b1, k, 1'b1, "c");       // bad key with a char
    for (int n = 0; n < 10; n++) begin
      send_char(alnum_from(rand_below(62)));
    end
    send_key(random_key());          // new key mid-stream
    for (int n = 0; n < 20; n++) begin
      send_char(alnum_from(rand_below(62)));
    end
    go_idle();
    repeat (4) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
